//--- bench/raster_fetch_checker.sv
`timescale 1ns/100ps
`include "raster_params.svh"

// Scoreboard and bus monitor for the rasterizer front end
module raster_fetch_checker (
    input logic                                   clk,
    input logic                                   reset,
    input logic                                   ready,
    input logic [`RASTER_SLICE_NUM-1:0]           slice_ready,
    input logic                                   out_valid,
    input logic [`RASTER_DIM_BITS-1:0]            out_x_loc,
    input logic [`RASTER_DIM_BITS-1:0]            out_y_loc,
    input logic [2:0][2:0][`RASTER_DATA_BITS-1:0] out_edges,
    input logic [`RASTER_DATA_BITS-1:0]           out_pid,
    input logic [$clog2(`RASTER_SLICE_NUM)-1:0]   out_slice_index,
    input logic                                   wb_cyc,
    input logic                                   wb_stb,
    input logic [`RASTER_ADDR_BITS-1:0]           wb_adr,
    input logic                                   wb_ack
);

    // Packet layout is {pid, x, y, nine edge words}
    localparam int PKT_BITS = 2 * `RASTER_DIM_BITS + 10 * `RASTER_DATA_BITS;
    localparam int EDGE_BITS = 9 * `RASTER_DATA_BITS;

    logic [PKT_BITS-1:0]          exp_q[$];
    string                        cur_test = "setup";
    int                           errors = 0;
    int                           errors_at_start = 0;
    int                           tests_run = 0;
    int                           tests_failed = 0;
    int                           packets_seen = 0;
    int                           quiet_mark = 0;
    logic [`RASTER_SLICE_NUM-1:0] sr_q = '0;
    logic                         adr_held = 1'b0;
    logic                         acked_q = 1'b0;
    logic [`RASTER_ADDR_BITS-1:0] adr_q;
    logic [`RASTER_ADDR_BITS-1:0] tbuf_lo = '0;
    logic [`RASTER_ADDR_BITS-1:0] tbuf_hi = '0;
    logic [`RASTER_ADDR_BITS-1:0] pbuf_lo = '0;
    logic [`RASTER_ADDR_BITS-1:0] pbuf_hi = '0;

    task automatic fail_value(input string what, input logic [PKT_BITS-1:0] exp,
                              input logic [PKT_BITS-1:0] act);
        errors++;
        $display("[FAIL] %s %s expected %0h actual %0h", cur_test, what, exp, act);
    endtask

    task automatic fail_plain(input string msg);
        errors++;
        $display("%s: %s", cur_test, msg);
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        int n;
        n = errors - errors_at_start;
        tests_run++;
        if (n == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, n);
        end
    endtask

    task automatic report_counts();
        $display("tests run %0d, failed %0d, failed checks %0d, packets seen %0d",
                 tests_run, tests_failed, errors, packets_seen);
    endtask

    function automatic int error_count();
        return errors;
    endfunction

    function automatic int pending_packets();
        return exp_q.size();
    endfunction

    task automatic expect_packet(input logic [31:0] pid, input logic [15:0] x,
                                 input logic [15:0] y, input logic [EDGE_BITS-1:0] edges);
        exp_q.push_back({pid, x, y, edges});
    endtask

    // Address windows that the current job may read
    task automatic set_regions(input logic [31:0] tbase, input logic [31:0] tbytes,
                               input logic [31:0] pbase, input logic [31:0] pbytes);
        tbuf_lo = tbase;
        tbuf_hi = tbase + tbytes;
        pbuf_lo = pbase;
        pbuf_hi = pbase + pbytes;
    endtask

    function automatic logic in_region(input logic [31:0] a);
        return (a >= tbuf_lo && a < tbuf_hi) || (a >= pbuf_lo && a < pbuf_hi);
    endfunction

    function automatic int lowest_ready(input logic [`RASTER_SLICE_NUM-1:0] bits);
        for (int i = 0; i < `RASTER_SLICE_NUM; i++) begin
            if (bits[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_reset_state();
        if (out_valid !== 1'b0) fail_value("out_valid", 0, out_valid);
        if (wb_cyc !== 1'b0) fail_value("wb_cyc", 0, wb_cyc);
        if (wb_stb !== 1'b0) fail_value("wb_stb", 0, wb_stb);
        if (ready !== 1'b1) fail_value("ready", 1, ready);
    endtask

    task automatic check_job_done();
        if (exp_q.size() != 0) begin
            fail_plain($sformatf("%0d expected packets were never dispatched", exp_q.size()));
        end
        if (ready !== 1'b1) fail_value("ready", 1, ready);
        exp_q.delete();
    endtask

    task automatic mark_quiet();
        quiet_mark = packets_seen;
    endtask

    task automatic check_quiet();
        if (packets_seen != quiet_mark) fail_value("packet count", quiet_mark, packets_seen);
    endtask

    // Consume the matching expected packet, or the closest one by pid
    task automatic match_packet(input logic [PKT_BITS-1:0] pkt);
        int hit;
        int near;
        hit = -1;
        near = -1;
        for (int i = 0; i < exp_q.size(); i++) begin
            if (hit < 0 && exp_q[i] == pkt) hit = i;
            if (near < 0 && exp_q[i][PKT_BITS-1 -: 32] == pkt[PKT_BITS-1 -: 32]) near = i;
        end
        if (hit >= 0) begin
            exp_q.delete(hit);
        end else if (exp_q.size() == 0) begin
            fail_plain($sformatf("extra packet for pid %0d after all were seen",
                                 pkt[PKT_BITS-1 -: 32]));
        end else begin
            if (near < 0) near = 0;
            fail_value("packet", exp_q[near], pkt);
            exp_q.delete(near);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            adr_held = 1'b0;
            acked_q  = 1'b0;
            sr_q     = '0;
        end else begin
            if (out_valid) begin
                packets_seen++;
                if (sr_q == '0) begin
                    fail_plain("packet dispatched while no slice was ready");
                end else if (out_slice_index != lowest_ready(sr_q)) begin
                    fail_value("slice index", lowest_ready(sr_q), out_slice_index);
                end
                match_packet({out_pid, out_x_loc, out_y_loc, out_edges});
            end

            if (wb_stb && !wb_cyc) fail_plain("wb_stb high without wb_cyc");
            if (adr_held && (!wb_cyc || wb_adr != adr_q)) begin
                fail_plain("cycle dropped or address moved before ack");
            end
            if (acked_q && wb_cyc) fail_plain("wb_cyc stayed high right after an ack");
            // Checked once, on the first cycle of each transfer
            if (wb_cyc && wb_stb && !adr_held && !in_region(wb_adr)) begin
                fail_plain($sformatf("read at %h outside the job buffers", wb_adr));
            end
            adr_held = wb_cyc && !wb_ack;
            acked_q  = wb_cyc && wb_ack;
            adr_q    = wb_adr;
            sr_q     = slice_ready;
        end
    end

endmodule

//--- bench/raster_fetch_tb.sv
`timescale 1ns/100ps
`include "raster_params.svh"

module raster_fetch_tb;

    localparam int MEM_WORDS    = 4096;
    localparam int NUM_JOBS     = 3;
    localparam int NUM_PIDS     = 16;
    localparam int PRIM_WORDS   = 9;
    localparam int DRAIN_CYCLES = 200;

    logic                                   clk;
    logic                                   reset;
    logic                                   start;
    logic [`RASTER_DATA_BITS-1:0]           num_tiles;
    logic [`RASTER_ADDR_BITS-1:0]           tbuf_baseaddr;
    logic [`RASTER_ADDR_BITS-1:0]           pbuf_baseaddr;
    logic [`RASTER_DATA_BITS-1:0]           pbuf_stride;
    logic                                   ready;
    logic [`RASTER_SLICE_NUM-1:0]           slice_ready;
    logic                                   out_valid;
    logic [`RASTER_DIM_BITS-1:0]            out_x_loc;
    logic [`RASTER_DIM_BITS-1:0]            out_y_loc;
    logic [2:0][2:0][`RASTER_DATA_BITS-1:0] out_edges;
    logic [`RASTER_DATA_BITS-1:0]           out_pid;
    logic [$clog2(`RASTER_SLICE_NUM)-1:0]   out_slice_index;
    logic                                   wb_cyc;
    logic                                   wb_stb;
    logic [`RASTER_ADDR_BITS-1:0]           wb_adr;
    logic [`RASTER_DATA_BITS-1:0]           wb_dat_i;
    logic                                   wb_ack;

    logic [31:0] mem [MEM_WORDS];
    integer      seed = 32'hf9a6;
    logic [31:0] job_tiles  [NUM_JOBS];
    logic [31:0] job_tbase  [NUM_JOBS];
    logic [31:0] job_pbase  [NUM_JOBS];
    logic [31:0] job_stride [NUM_JOBS];
    logic [31:0] job_tbytes [NUM_JOBS];
    int          total_words = 0;
    int          limit_cycles = 0;
    logic        hold_slices = 1'b0;
    int          zero_left = 0;
    int          wait_left = -1;

    raster_fetch u_raster_fetch (
        .clk             (clk),
        .reset           (reset),
        .start           (start),
        .num_tiles       (num_tiles),
        .tbuf_baseaddr   (tbuf_baseaddr),
        .pbuf_baseaddr   (pbuf_baseaddr),
        .pbuf_stride     (pbuf_stride),
        .ready           (ready),
        .slice_ready     (slice_ready),
        .out_valid       (out_valid),
        .out_x_loc       (out_x_loc),
        .out_y_loc       (out_y_loc),
        .out_edges       (out_edges),
        .out_pid         (out_pid),
        .out_slice_index (out_slice_index),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .wb_adr          (wb_adr),
        .wb_dat_i        (wb_dat_i),
        .wb_ack          (wb_ack)
    );

    raster_fetch_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Tile records, primitive buffers and a background fill for all jobs
    task automatic build_image();
        logic [31:0] ptr;
        logic [31:0] n;
        int          tiles;
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = 32'h5a00_0000 ^ (a * 32'h0001_0003);
        end
        for (int j = 0; j < NUM_JOBS; j++) begin
            job_tbase[j]  = 32'h0000_0400 + j * 32'h0000_0200;
            job_pbase[j]  = 32'h0000_2000 + j * 32'h0000_0400;
            job_stride[j] = 36 + 4 * rand_below(4);
            // Job 1 is the largest, so the stall stretch meets a busy station
            tiles = (j == 1) ? 4 : 1 + rand_below(4);
            job_tiles[j] = tiles;
            ptr = job_tbase[j];
            for (int t = 0; t < tiles; t++) begin
                n = (j == 1) ? 5 : 1 + rand_below(5);
                mem[ptr >> 2] = $random(seed);
                mem[(ptr >> 2) + 1] = n;
                ptr = ptr + 8;
                for (int k = 0; k < n; k++) begin
                    mem[ptr >> 2] = rand_below(NUM_PIDS);
                    ptr = ptr + 4;
                end
                total_words += 2 + n * (1 + PRIM_WORDS);
            end
            job_tbytes[j] = ptr - job_tbase[j];
            for (int p = 0; p < NUM_PIDS; p++) begin
                for (int i = 0; i < PRIM_WORDS; i++) begin
                    mem[(job_pbase[j] + p * job_stride[j] + 4 * i) >> 2] = $random(seed);
                end
            end
        end
    endtask

    // Walk the tile buffer by the layout rules and list every packet
    task automatic queue_expected(input int j);
        logic [31:0]     ptr;
        logic [31:0]     coord;
        logic [31:0]     n;
        logic [31:0]     pid;
        logic [31:0]     paddr;
        logic [15:0]     x;
        logic [15:0]     y;
        logic [9*32-1:0] edges;
        ptr = job_tbase[j];
        for (int t = 0; t < job_tiles[j]; t++) begin
            coord = mem[ptr >> 2];
            n = mem[(ptr >> 2) + 1];
            ptr = ptr + 8;
            x = coord[15:0] << `RASTER_TILE_BITS;
            y = coord[31:16] << `RASTER_TILE_BITS;
            for (int k = 0; k < n; k++) begin
                pid = mem[ptr >> 2];
                ptr = ptr + 4;
                paddr = job_pbase[j] + pid * job_stride[j];
                for (int i = 0; i < PRIM_WORDS; i++) begin
                    edges[32*i +: 32] = mem[(paddr >> 2) + i];
                end
                u_checker.expect_packet(pid, x, y, edges);
            end
        end
        u_checker.set_regions(job_tbase[j], job_tbytes[j], job_pbase[j],
                              NUM_PIDS * job_stride[j]);
    endtask

    task automatic start_job(input int j);
        queue_expected(j);
        @(negedge clk);
        while (!ready) @(negedge clk);
        start         = 1'b1;
        num_tiles     = job_tiles[j];
        tbuf_baseaddr = job_tbase[j];
        pbuf_baseaddr = job_pbase[j];
        pbuf_stride   = job_stride[j];
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic finish_job();
        int drain;
        drain = 0;
        while (!ready) @(negedge clk);
        // Station may still hold entries once fetching is over
        while (u_checker.pending_packets() > 0 && drain < DRAIN_CYCLES) begin
            @(negedge clk);
            drain++;
        end
        u_checker.check_job_done();
    endtask

    // Wishbone slave with 0 to 3 wait states per read
    always @(negedge clk) begin
        if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (wait_left < 0) wait_left = rand_below(4);
            if (wait_left == 0) begin
                wb_dat_i  = mem[wb_adr[13:2]];
                wb_ack    = 1'b1;
                wait_left = -1;
            end else begin
                wait_left--;
            end
        end

        // Random slice readiness with occasional all-zero stretches
        if (hold_slices || reset !== 1'b0) begin
            slice_ready = '0;
        end else if (zero_left > 0) begin
            slice_ready = '0;
            zero_left--;
        end else begin
            if (rand_below(20) == 0) zero_left = 5 + rand_below(16);
            slice_ready = $random(seed);
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the DUT stopped making progress", limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        reset         = 1'b1;
        start         = 1'b0;
        num_tiles     = '0;
        tbuf_baseaddr = '0;
        pbuf_baseaddr = '0;
        pbuf_stride   = '0;
        slice_ready   = '0;
        wb_dat_i      = '0;
        wb_ack        = 1'b0;
        build_image();
        limit_cycles = 1000 + total_words * 8 + NUM_JOBS * (DRAIN_CYCLES + 100) + 200;

        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        u_checker.start_test("reset_state");
        u_checker.check_reset_state();
        u_checker.finish_test();

        u_checker.start_test("job_0");
        start_job(0);
        finish_job();
        u_checker.finish_test();

        // Hold every slice off for 40 cycles in the middle of job 1
        u_checker.start_test("back_pressure");
        start_job(1);
        repeat (150) @(negedge clk);
        hold_slices = 1'b1;
        repeat (2) @(negedge clk);
        u_checker.mark_quiet();
        repeat (40) @(negedge clk);
        u_checker.check_quiet();
        hold_slices = 1'b0;
        u_checker.finish_test();

        u_checker.start_test("job_1");
        finish_job();
        u_checker.finish_test();

        u_checker.start_test("job_2");
        start_job(2);
        finish_job();
        u_checker.finish_test();

        u_checker.report_counts();
        if (u_checker.error_count() == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- hdl/mem_streamer.sv
`timescale 1ns/100ps
`include "raster_params.svh"

// Breaks one multi-lane read request into single Wishbone classic reads,
// one transfer in flight, and hands back all lanes at once with the tag
module mem_streamer (
    input  logic                                                clk,
    input  logic                                                reset,

    input  logic                                                req_valid,
    output logic                                                req_ready,
    input  raster_pkg::lane_mask_t                              req_mask,
    input  logic [`RASTER_NUM_LANES-1:0][`RASTER_ADDR_BITS-1:0] req_addr,
    input  raster_pkg::fetch_tag_t                              req_tag,

    output logic                                                rsp_valid,
    output logic [`RASTER_NUM_LANES-1:0][`RASTER_DATA_BITS-1:0] rsp_data,
    output raster_pkg::fetch_tag_t                              rsp_tag,

    output logic                                                wb_cyc,
    output logic                                                wb_stb,
    output logic [`RASTER_ADDR_BITS-1:0]                        wb_adr,
    input  logic [`RASTER_DATA_BITS-1:0]                        wb_dat_i,
    input  logic                                                wb_ack
);

    import raster_pkg::*;

    localparam int LANE_BITS = $clog2(`RASTER_NUM_LANES);

    logic                                                busy;
    lane_mask_t                                          pending;
    lane_mask_t                                          pending_next;
    logic [LANE_BITS-1:0]                                cur_lane;
    logic [LANE_BITS-1:0]                                next_lane;
    logic                                                next_found;
    logic [`RASTER_NUM_LANES-1:0][`RASTER_ADDR_BITS-1:0] addr_q;

    // Next lane to read, lowest first
    prio_encoder #(
        .N(`RASTER_NUM_LANES)
    ) u_lane_sel (
        .bits  (pending),
        .index (next_lane),
        .found (next_found)
    );

    assign req_ready = !busy;

    // Classic cycles, strobe follows cycle
    assign wb_stb = wb_cyc;

    // Pending lanes once the lane in flight is acked
    always_comb begin
        pending_next = pending;
        pending_next[cur_lane] = 1'b0;
    end

    always_ff @(posedge clk) begin
        rsp_valid <= 1'b0;

        if (req_valid && req_ready) begin
            busy    <= 1'b1;
            pending <= req_mask;
            addr_q  <= req_addr;
            rsp_tag <= req_tag;
        end else if (busy && !wb_cyc) begin
            if (next_found) begin
                // Bus was idle for at least this cycle, start the next word
                wb_cyc   <= 1'b1;
                wb_adr   <= addr_q[next_lane];
                cur_lane <= next_lane;
            end else begin
                // Request with no live lane
                busy      <= 1'b0;
                rsp_valid <= 1'b1;
            end
        end else if (wb_cyc && wb_ack) begin
            wb_cyc             <= 1'b0;
            rsp_data[cur_lane] <= wb_dat_i;
            pending            <= pending_next;
            // Last live lane, response goes out next cycle
            if (pending_next == '0) begin
                busy      <= 1'b0;
                rsp_valid <= 1'b1;
            end
        end

        if (reset) begin
            busy      <= 1'b0;
            pending   <= '0;
            wb_cyc    <= 1'b0;
            rsp_valid <= 1'b0;
        end
    end

endmodule

//--- hdl/prio_encoder.sv
`timescale 1ns/100ps

// Lowest-set-bit encoder
module prio_encoder #(
    parameter int N = 8
) (
    input  logic [N-1:0]         bits,
    output logic [$clog2(N)-1:0] index,
    output logic                 found
);

    localparam int IDX_BITS = $clog2(N);

    always_comb begin
        index = '0;
        found = 1'b0;
        // Walk down so the lowest set bit is the last one written
        for (int i = N - 1; i >= 0; i--) begin
            if (bits[i]) begin
                index = IDX_BITS'(i);
                found = 1'b1;
            end
        end
    end

endmodule

//--- hdl/raster_fetch.sv
`timescale 1ns/100ps
`include "raster_params.svh"

// Rasterizer memory front end
module raster_fetch (
    input  logic                                   clk,
    input  logic                                   reset,

    input  logic                                   start,
    input  logic [`RASTER_DATA_BITS-1:0]           num_tiles,
    input  logic [`RASTER_ADDR_BITS-1:0]           tbuf_baseaddr,
    input  logic [`RASTER_ADDR_BITS-1:0]           pbuf_baseaddr,
    input  logic [`RASTER_DATA_BITS-1:0]           pbuf_stride,
    output logic                                   ready,

    input  logic [`RASTER_SLICE_NUM-1:0]           slice_ready,
    output logic                                   out_valid,
    output logic [`RASTER_DIM_BITS-1:0]            out_x_loc,
    output logic [`RASTER_DIM_BITS-1:0]            out_y_loc,
    output logic [2:0][2:0][`RASTER_DATA_BITS-1:0] out_edges,
    output logic [`RASTER_DATA_BITS-1:0]           out_pid,
    output logic [$clog2(`RASTER_SLICE_NUM)-1:0]   out_slice_index,

    output logic                                   wb_cyc,
    output logic                                   wb_stb,
    output logic [`RASTER_ADDR_BITS-1:0]           wb_adr,
    input  logic [`RASTER_DATA_BITS-1:0]           wb_dat_i,
    input  logic                                   wb_ack
);

    import raster_pkg::*;

    // Fetch sequencer to streamer
    logic                                                req_valid;
    logic                                                req_ready;
    lane_mask_t                                          req_mask;
    logic [`RASTER_NUM_LANES-1:0][`RASTER_ADDR_BITS-1:0] req_addr;
    fetch_tag_t                                          req_tag;
    logic                                                rsp_valid;
    logic [`RASTER_NUM_LANES-1:0][`RASTER_DATA_BITS-1:0] rsp_data;
    fetch_tag_t                                          rsp_tag;

    raster_mem u_raster_mem (
        .clk             (clk),
        .reset           (reset),
        .start           (start),
        .num_tiles       (num_tiles),
        .tbuf_baseaddr   (tbuf_baseaddr),
        .pbuf_baseaddr   (pbuf_baseaddr),
        .pbuf_stride     (pbuf_stride),
        .ready           (ready),
        .slice_ready     (slice_ready),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .req_mask        (req_mask),
        .req_addr        (req_addr),
        .req_tag         (req_tag),
        .rsp_valid       (rsp_valid),
        .rsp_data        (rsp_data),
        .rsp_tag         (rsp_tag),
        .out_valid       (out_valid),
        .out_x_loc       (out_x_loc),
        .out_y_loc       (out_y_loc),
        .out_edges       (out_edges),
        .out_pid         (out_pid),
        .out_slice_index (out_slice_index)
    );

    mem_streamer u_mem_streamer (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_mask  (req_mask),
        .req_addr  (req_addr),
        .req_tag   (req_tag),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_tag   (rsp_tag),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_adr    (wb_adr),
        .wb_dat_i  (wb_dat_i),
        .wb_ack    (wb_ack)
    );

endmodule

//--- hdl/raster_mem.sv
`timescale 1ns/100ps
`include "raster_params.svh"

// Walks the tile buffer of a draw job, fetches each listed primitive,
// parks it in the reservation station and hands it to a free raster slice
module raster_mem (
    input  logic                                                clk,
    input  logic                                                reset,

    input  logic                                                start,
    input  logic [`RASTER_DATA_BITS-1:0]                        num_tiles,
    input  logic [`RASTER_ADDR_BITS-1:0]                        tbuf_baseaddr,
    input  logic [`RASTER_ADDR_BITS-1:0]                        pbuf_baseaddr,
    input  logic [`RASTER_DATA_BITS-1:0]                        pbuf_stride,
    output logic                                                ready,

    input  logic [`RASTER_SLICE_NUM-1:0]                        slice_ready,

    output logic                                                req_valid,
    input  logic                                                req_ready,
    output raster_pkg::lane_mask_t                              req_mask,
    output logic [`RASTER_NUM_LANES-1:0][`RASTER_ADDR_BITS-1:0] req_addr,
    output raster_pkg::fetch_tag_t                              req_tag,

    input  logic                                                rsp_valid,
    input  logic [`RASTER_NUM_LANES-1:0][`RASTER_DATA_BITS-1:0] rsp_data,
    input  raster_pkg::fetch_tag_t                              rsp_tag,

    output logic                                                out_valid,
    output logic [`RASTER_DIM_BITS-1:0]                         out_x_loc,
    output logic [`RASTER_DIM_BITS-1:0]                         out_y_loc,
    output logic [2:0][2:0][`RASTER_DATA_BITS-1:0]              out_edges,
    output logic [`RASTER_DATA_BITS-1:0]                        out_pid,
    output logic [$clog2(`RASTER_SLICE_NUM)-1:0]                out_slice_index
);

    import raster_pkg::*;

    localparam int RS_BITS    = $clog2(`RASTER_RS_SIZE);
    localparam int SLICE_BITS = $clog2(`RASTER_SLICE_NUM);

    // Lanes read per fetch type
    localparam lane_mask_t TILE_MASK = lane_mask_t'(2'b11);
    localparam lane_mask_t ID_MASK   = lane_mask_t'(1'b1);
    localparam lane_mask_t DATA_MASK = '1;

    // Sequencer state
    logic                         job_busy;
    logic                         req_pending;
    logic [`RASTER_ADDR_BITS-1:0] tbuf_ptr;
    logic [`RASTER_ADDR_BITS-1:0] pbuf_base;
    logic [`RASTER_DATA_BITS-1:0] prim_stride;
    logic [`RASTER_DATA_BITS-1:0] tiles_total;
    logic [`RASTER_DATA_BITS-1:0] tile_count;
    logic [`RASTER_DATA_BITS-1:0] prims_total;
    logic [`RASTER_DATA_BITS-1:0] prim_count;
    logic [`RASTER_DIM_BITS-1:0]  tile_x;
    logic [`RASTER_DIM_BITS-1:0]  tile_y;
    logic [`RASTER_DATA_BITS-1:0] cur_pid;
    logic [`RASTER_ADDR_BITS-1:0] prim_addr;

    // Reservation station
    logic [`RASTER_RS_SIZE-1:0]                 rs_valid;
    logic [`RASTER_DIM_BITS-1:0]                rs_x     [`RASTER_RS_SIZE];
    logic [`RASTER_DIM_BITS-1:0]                rs_y     [`RASTER_RS_SIZE];
    logic [`RASTER_DATA_BITS-1:0]               rs_pid   [`RASTER_RS_SIZE];
    logic [2:0][2:0][`RASTER_DATA_BITS-1:0]     rs_edges [`RASTER_RS_SIZE];

    logic [RS_BITS-1:0]    free_idx;
    logic                  free_found;
    logic [RS_BITS-1:0]    entry_idx;
    logic                  entry_found;
    logic [SLICE_BITS-1:0] slice_idx;
    logic                  slice_found;

    prio_encoder #(
        .N(`RASTER_RS_SIZE)
    ) u_free_sel (
        .bits  (~rs_valid),
        .index (free_idx),
        .found (free_found)
    );

    prio_encoder #(
        .N(`RASTER_RS_SIZE)
    ) u_entry_sel (
        .bits  (rs_valid),
        .index (entry_idx),
        .found (entry_found)
    );

    prio_encoder #(
        .N(`RASTER_SLICE_NUM)
    ) u_slice_sel (
        .bits  (slice_ready),
        .index (slice_idx),
        .found (slice_found)
    );

    assign ready = !job_busy && req_ready && free_found;

    // A request waits while the station is full
    assign req_valid = req_pending && free_found;

    // Start of the primitive named by an id response
    assign prim_addr = pbuf_base + rsp_data[0] * prim_stride;

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_pending <= 1'b0;
        end

        if (start && ready) begin
            job_busy    <= (num_tiles != '0);
            req_pending <= (num_tiles != '0);
            pbuf_base   <= pbuf_baseaddr;
            prim_stride <= pbuf_stride;
            tiles_total <= num_tiles;
            tile_count  <= '0;
            prim_count  <= '0;
            // First tile header pair
            req_tag     <= TILE_FETCH;
            req_mask    <= TILE_MASK;
            req_addr[0] <= tbuf_baseaddr;
            req_addr[1] <= tbuf_baseaddr + 4;
            tbuf_ptr    <= tbuf_baseaddr + 8;
        end else if (rsp_valid && job_busy) begin
            case (rsp_tag)
                TILE_FETCH: begin
                    tile_x      <= rsp_data[0][`RASTER_DIM_BITS-1:0] << `RASTER_TILE_BITS;
                    tile_y      <= rsp_data[0][2*`RASTER_DIM_BITS-1:`RASTER_DIM_BITS]
                                   << `RASTER_TILE_BITS;
                    prims_total <= rsp_data[1];
                    req_pending <= 1'b1;
                    req_tag     <= PRIM_ID_FETCH;
                    req_mask    <= ID_MASK;
                    req_addr[0] <= tbuf_ptr;
                    tbuf_ptr    <= tbuf_ptr + 4;
                end
                PRIM_ID_FETCH: begin
                    cur_pid     <= rsp_data[0];
                    req_pending <= 1'b1;
                    req_tag     <= PRIM_DATA_FETCH;
                    req_mask    <= DATA_MASK;
                    for (int i = 0; i < `RASTER_NUM_LANES; i++) begin
                        req_addr[i] <= prim_addr + `RASTER_ADDR_BITS'(4 * i);
                    end
                end
                PRIM_DATA_FETCH: begin
                    // A free entry is guaranteed, the request was gated on it
                    rs_valid[free_idx] <= 1'b1;
                    rs_x[free_idx]     <= tile_x;
                    rs_y[free_idx]     <= tile_y;
                    rs_pid[free_idx]   <= cur_pid;
                    for (int e = 0; e < 3; e++) begin
                        for (int c = 0; c < 3; c++) begin
                            rs_edges[free_idx][e][c] <= rsp_data[3 * e + c];
                        end
                    end

                    if (prim_count + 1 == prims_total) begin
                        prim_count <= '0;
                        tile_count <= tile_count + 1;
                        if (tile_count + 1 == tiles_total) begin
                            job_busy <= 1'b0;
                        end else begin
                            // Next tile record follows the last id
                            req_pending <= 1'b1;
                            req_tag     <= TILE_FETCH;
                            req_mask    <= TILE_MASK;
                            req_addr[0] <= tbuf_ptr;
                            req_addr[1] <= tbuf_ptr + 4;
                            tbuf_ptr    <= tbuf_ptr + 8;
                        end
                    end else begin
                        prim_count  <= prim_count + 1;
                        req_pending <= 1'b1;
                        req_tag     <= PRIM_ID_FETCH;
                        req_mask    <= ID_MASK;
                        req_addr[0] <= tbuf_ptr;
                        tbuf_ptr    <= tbuf_ptr + 4;
                    end
                end
                default: begin
                    req_pending <= 1'b0;
                end
            endcase
        end

        // Dispatch, the cleared entry never equals the one just filled
        out_valid <= 1'b0;
        if (entry_found && slice_found) begin
            out_valid           <= 1'b1;
            out_x_loc           <= rs_x[entry_idx];
            out_y_loc           <= rs_y[entry_idx];
            out_pid             <= rs_pid[entry_idx];
            out_edges           <= rs_edges[entry_idx];
            out_slice_index     <= slice_idx;
            rs_valid[entry_idx] <= 1'b0;
        end

        if (reset) begin
            job_busy    <= 1'b0;
            req_pending <= 1'b0;
            tile_count  <= '0;
            prim_count  <= '0;
            tiles_total <= '0;
            rs_valid    <= '0;
            out_valid   <= 1'b0;
        end
    end

endmodule

//--- hdl/raster_params.svh
`ifndef RASTER_PARAMS_SVH
`define RASTER_PARAMS_SVH

// Memory word and edge coefficient width
`define RASTER_DATA_BITS 32

// Byte address width on the memory side
`define RASTER_ADDR_BITS 32

// Pixel coordinate width
`define RASTER_DIM_BITS 16

// Tiles are 16x16 pixels
`define RASTER_TILE_BITS 4

`define RASTER_SLICE_NUM 4
`define RASTER_RS_SIZE 8

// Largest request is one primitive, three edges of three coefficients
`define RASTER_NUM_LANES 9

`endif

//--- hdl/raster_pkg.sv
`include "raster_params.svh"

package raster_pkg;

    // What a pending memory request will return
    typedef enum logic [1:0] {
        TILE_FETCH      = 2'd1,
        PRIM_ID_FETCH   = 2'd2,
        PRIM_DATA_FETCH = 2'd3
    } fetch_tag_t;

    // One bit per request lane, set for lanes that are read
    typedef logic [`RASTER_NUM_LANES-1:0] lane_mask_t;

endpackage

//--- raster_fetch.f
+incdir+hdl
hdl/raster_pkg.sv
hdl/prio_encoder.sv
hdl/mem_streamer.sv
hdl/raster_mem.sv
hdl/raster_fetch.sv
bench/raster_fetch_checker.sv
bench/raster_fetch_tb.sv
